// File: verif/npc_testdata.txt
# I <address> <word> is a program word, R <pc> <rd> <wen> <wdata> an expected retirement, all hex
# rd and wdata are compared only on lines with wen 1
I 80000000 00500093
I 80000004 00300113
I 80000008 002081B3
I 8000000C 40218233
I 80000010 0011F2B3
I 80000014 0011E333
I 80000018 0011C3B3
I 8000001C 12345437
I 80000020 00120663
I 80000024 00100493
I 80000028 00200493
I 8000002C 00119663
I 80000030 00300493
I 80000034 00400493
I 80000038 00118463
I 8000003C 00708013
I 80000040 00100533
I 80000044 00C005EF
I 80000048 00500493
I 8000004C 00600493
I 80000050 00A58633
I 80000054 0000006F
I 80000058 00000013
I 8000005C 00000013
R 80000000 01 1 0000000000000005
R 80000004 02 1 0000000000000003
R 80000008 03 1 0000000000000008
R 8000000C 04 1 0000000000000005
R 80000010 05 1 0000000000000000
R 80000014 06 1 000000000000000D
R 80000018 07 1 000000000000000D
R 8000001C 08 1 0000000012345000
R 80000020 00 0 0000000000000000
R 8000002C 00 0 0000000000000000
R 80000038 00 0 0000000000000000
R 8000003C 00 0 000000000000000C
R 80000040 0A 1 0000000000000005
R 80000044 0B 1 0000000080000048
R 80000050 0C 1 000000008000004D
R 80000054 00 0 0000000080000058

// File: build.f
hdl/npc_pkg.sv
hdl/regfile.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/writeback_unit.sv
hdl/npc_top.sv
verif/npc_props.sv
verif/npc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the pipeline and its testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module npc_tb -o npc_sim

# the log decides the result
./obj_dir/npc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
exit 0

// File: verif/npc_tb.sv
// testbench for the rv64i pipeline that serves instruction memory and checks each retirement
module npc_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam string TESTDATA = "verif/npc_testdata.txt";

	// starts low without an edge at time zero
	logic              clk = 1'b0;
	logic              rst;
	npc_pkg::inst_t    imem_data;
	npc_pkg::xlen_t    imem_addr;
	logic              retire_valid;
	npc_pkg::xlen_t    retire_pc;
	npc_pkg::reg_idx_t retire_rd;
	logic              retire_wen;
	npc_pkg::xlen_t    retire_wdata;

	// sparse program image
	npc_pkg::inst_t    imem [npc_pkg::xlen_t];
	// expected retire trace kept as one queue per field
	npc_pkg::xlen_t    exp_pc [$];
	npc_pkg::reg_idx_t exp_rd [$];
	logic              exp_wen [$];
	npc_pkg::xlen_t    exp_wdata [$];
	int                total_expected;
	int                retired;
	int                watchdog_cycles;

	npc_top npc_top_inst (.clk, .rst, .imem_data, .imem_addr, .retire_valid, .retire_pc,
		.retire_rd, .retire_wen, .retire_wdata);

	// 100 ns period
	always #50 clk = ~clk;

	// ****************************************
	// helpers
	// ****************************************
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// I lines hold program words and R lines hold retirements
	// any other line is skipped
	task automatic load_testdata();
		int          fd;
		int          n;
		string       line;
		logic [63:0] f0, f1, f2, f3;
		fd = $fopen(TESTDATA, "r");
		if (fd == 0) begin
			abort_run({"cannot open the data file ", TESTDATA});
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line[0] == "I") begin
					n = $sscanf(line, "I %h %h", f0, f1);
					if (n != 2) begin
						abort_run({"malformed program line in data file: ", line});
					end else begin
						imem[f0] = f1[31:0];
					end
				end else if (line.len() > 0 && line[0] == "R") begin
					n = $sscanf(line, "R %h %h %h %h", f0, f1, f2, f3);
					if (n != 4) begin
						abort_run({"malformed retire line in data file: ", line});
					end else begin
						exp_pc.push_back(f0);
						exp_rd.push_back(f1[4:0]);
						exp_wen.push_back(f2[0]);
						exp_wdata.push_back(f3);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ****************************************
	// instruction memory
	// ****************************************
	// word for the registered fetch address settles well before the next edge
	always @(posedge clk) begin
		#10;
		if (imem.exists(imem_addr)) begin
			imem_data = imem[imem_addr];
		end else begin
			abort_run($sformatf("fetch from unmapped address %h", imem_addr));
		end
	end

	// ****************************************
	// retire checker
	// ****************************************
	// sampled on the falling edge where the retire port is settled
	always @(negedge clk) begin
		if (retire_valid === 1'b1 && exp_pc.size() > 0) begin
			check_value($sformatf("retire %0d pc", retired), exp_pc[0], retire_pc);
			check_value($sformatf("retire %0d wen", retired), 64'(exp_wen[0]), 64'(retire_wen));
			// rd and data only mean something when a register is written
			if (exp_wen[0]) begin
				check_value($sformatf("retire %0d rd", retired), 64'(exp_rd[0]), 64'(retire_rd));
				check_value($sformatf("retire %0d wdata", retired), exp_wdata[0], retire_wdata);
			end
			void'(exp_pc.pop_front());
			void'(exp_rd.pop_front());
			void'(exp_wen.pop_front());
			void'(exp_wdata.pop_front());
			retired++;
		end
	end

	// ****************************************
	// main sequence
	// ****************************************
	initial begin
		rst             = 1'b1;
		imem_data       = '0;
		retired         = 0;
		watchdog_cycles = 0;
		load_testdata();
		total_expected = exp_pc.size();
		if (total_expected == 0) begin
			abort_run("the data file holds no expected retirements");
		end else begin
			watchdog_cycles = total_expected * 20 + 100;
			repeat (3) @(posedge clk);
			#10;
			rst = 1'b0;
			// first fetch at reset address with the pipeline still empty
			@(negedge clk);
			check_value("reset fetch address", npc_pkg::RESET_PC, imem_addr);
			check_value("reset retire idle", 64'd0, 64'(retire_valid));
			// extra retirements of the trailing jal loop are ignored
			while (exp_pc.size() != 0) begin
				@(posedge clk);
			end
			repeat (2) @(posedge clk);
			$display("=== PASS ===");
			$finish;
		end
	end

	// watchdog limit scales with trace length
	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk);
		abort_run($sformatf("watchdog expired after %0d cycles with %0d of %0d retirements seen",
			watchdog_cycles, retired, total_expected));
	end

endmodule

// File: verif/npc_props.sv
// concurrent checks on the pipeline top level, attached to npc_top through bind
module npc_props (
	input logic              clk,
	input logic              rst,
	input npc_pkg::xlen_t    imem_addr,
	input logic              retire_valid,
	input npc_pkg::reg_idx_t retire_rd,
	input logic              retire_wen
);
	timeunit 1ns;
	timeprecision 100ps;

	// ****************************************
	// properties, checked mid-cycle
	// ****************************************
	// nothing retires while held in reset
	property no_retire_in_reset;
		@(negedge clk) rst |-> !retire_valid;
	endproperty

	// fetch address always on a word boundary
	property fetch_word_aligned;
		@(negedge clk) imem_addr[1:0] == 2'b00;
	endproperty

	// x0 never reported as written
	property no_write_to_x0;
		@(negedge clk) !(retire_wen && (retire_rd == 5'd0));
	endproperty

	no_retire_in_reset_a: assert property (no_retire_in_reset)
		else $error("retire_valid high during reset");
	fetch_word_aligned_a: assert property (fetch_word_aligned)
		else $error("imem_addr not word aligned");
	no_write_to_x0_a: assert property (no_write_to_x0)
		else $error("retire_wen high with retire_rd zero");

endmodule

bind npc_top npc_props npc_props_inst (.clk, .rst, .imem_addr, .retire_valid, .retire_rd,
	.retire_wen);

// File: hdl/npc_top.sv
// top level of the four-stage rv64i pipeline, wires the stages to the register file
module npc_top (
	input  logic               clk,
	input  logic               rst,
	input  npc_pkg::inst_t     imem_data,
	output npc_pkg::xlen_t     imem_addr,
	output logic               retire_valid,
	output npc_pkg::xlen_t     retire_pc,
	output npc_pkg::reg_idx_t  retire_rd,
	output logic               retire_wen,
	output npc_pkg::xlen_t     retire_wdata
);

	// fetch to decode
	logic              fd_valid, fd_ready;
	npc_pkg::xlen_t    fd_pc;
	npc_pkg::inst_t    fd_inst;
	// decode to execute
	logic              dx_valid, dx_ready, dx_wen;
	npc_pkg::xlen_t    dx_pc, dx_src_a, dx_src_b, dx_imm;
	npc_pkg::alu_op_t  dx_op;
	npc_pkg::reg_idx_t dx_rd;
	// execute to writeback, no ready
	logic              xw_valid, xw_wen;
	npc_pkg::xlen_t    xw_pc, xw_wdata;
	npc_pkg::reg_idx_t xw_rd;
	// redirect from execute
	logic              redirect;
	npc_pkg::xlen_t    redirect_pc;
	// register file ports
	npc_pkg::reg_idx_t rs1, rs2, rf_rd;
	npc_pkg::xlen_t    rs1_data, rs2_data, rf_wdata;
	logic              rf_wen;

	// ****************************************
	// stages
	// ****************************************
	fetch_unit fetch_unit_inst (.clk, .rst, .redirect, .redirect_pc, .imem_data, .fd_ready,
		.imem_addr, .fd_valid, .fd_pc, .fd_inst);

	decode_unit decode_unit_inst (.clk, .rst, .fd_valid, .fd_pc, .fd_inst, .redirect,
		.rs1_data, .rs2_data, .dx_ready, .rf_wen, .rf_rd, .fd_ready, .rs1, .rs2,
		.dx_valid, .dx_pc, .dx_op, .dx_src_a, .dx_src_b, .dx_imm, .dx_rd, .dx_wen);

	execute_unit execute_unit_inst (.clk, .rst, .dx_valid, .dx_pc, .dx_op, .dx_src_a,
		.dx_src_b, .dx_imm, .dx_rd, .dx_wen, .dx_ready, .redirect, .redirect_pc,
		.xw_valid, .xw_pc, .xw_rd, .xw_wen, .xw_wdata);

	writeback_unit writeback_unit_inst (.xw_valid, .xw_pc, .xw_rd, .xw_wen, .xw_wdata,
		.rf_wen, .rf_rd, .rf_wdata, .retire_valid, .retire_pc, .retire_rd, .retire_wen,
		.retire_wdata);

	// ****************************************
	// register file
	// ****************************************
	regfile regfile_inst (.clk, .rs1, .rs2, .wen(rf_wen), .rd(rf_rd), .wdata(rf_wdata),
		.rs1_data, .rs2_data);

endmodule

// File: hdl/writeback_unit.sv
// writeback stage, forms the register write and reports each finished instruction on retire
module writeback_unit (
	input  logic               xw_valid,
	input  npc_pkg::xlen_t     xw_pc,
	input  npc_pkg::reg_idx_t  xw_rd,
	input  logic               xw_wen,
	input  npc_pkg::xlen_t     xw_wdata,
	output logic               rf_wen,
	output npc_pkg::reg_idx_t  rf_rd,
	output npc_pkg::xlen_t     rf_wdata,
	output logic               retire_valid,
	output npc_pkg::xlen_t     retire_pc,
	output npc_pkg::reg_idx_t  retire_rd,
	output logic               retire_wen,
	output npc_pkg::xlen_t     retire_wdata
);

	// ****************************************
	// register write
	// ****************************************
	// x0 writes suppressed, scoreboard sees same enable
	assign rf_wen   = xw_valid && xw_wen && (xw_rd != 5'd0);
	assign rf_rd    = xw_rd;
	assign rf_wdata = xw_wdata;

	// ****************************************
	// retire port
	// ****************************************
	// every valid instr retires, branches included
	assign retire_valid = xw_valid;
	assign retire_pc    = xw_pc;
	assign retire_rd    = xw_rd;
	// reports the real write, not the decoded intent
	assign retire_wen   = rf_wen;
	assign retire_wdata = xw_wdata;

endmodule

// File: hdl/execute_unit.sv
// execute stage, alu, branch and jump resolution, redirect and the execute-to-writeback register
module execute_unit (
	input  logic               clk,
	input  logic               rst,
	input  logic               dx_valid,
	input  npc_pkg::xlen_t     dx_pc,
	input  npc_pkg::alu_op_t   dx_op,
	input  npc_pkg::xlen_t     dx_src_a,
	input  npc_pkg::xlen_t     dx_src_b,
	input  npc_pkg::xlen_t     dx_imm,
	input  npc_pkg::reg_idx_t  dx_rd,
	input  logic               dx_wen,
	output logic               dx_ready,
	output logic               redirect,
	output npc_pkg::xlen_t     redirect_pc,
	output logic               xw_valid,
	output npc_pkg::xlen_t     xw_pc,
	output npc_pkg::reg_idx_t  xw_rd,
	output logic               xw_wen,
	output npc_pkg::xlen_t     xw_wdata
);

	npc_pkg::xlen_t result;
	npc_pkg::xlen_t link_pc;
	logic           src_eq;
	logic           taken;

	// single-cycle stage, never back-pressures
	assign dx_ready = 1'b1;

	assign link_pc = dx_pc + 64'd4;
	assign src_eq  = (dx_src_a == dx_src_b);

	// ****************************************
	// alu
	// ****************************************
	always_comb begin
		case (dx_op)
			npc_pkg::ALU_ADD:    result = dx_src_a + dx_src_b;
			npc_pkg::ALU_SUB:    result = dx_src_a - dx_src_b;
			npc_pkg::ALU_AND:    result = dx_src_a & dx_src_b;
			npc_pkg::ALU_OR:     result = dx_src_a | dx_src_b;
			npc_pkg::ALU_XOR:    result = dx_src_a ^ dx_src_b;
			// lui, src_b already holds the u immediate
			npc_pkg::ALU_PASS_B: result = dx_src_b;
			// link address
			npc_pkg::ALU_JAL:    result = link_pc;
			default:             result = '0;
		endcase
	end

	// ****************************************
	// branch and jump resolution
	// ****************************************
	always_comb begin
		case (dx_op)
			npc_pkg::ALU_BEQ: taken = src_eq;
			npc_pkg::ALU_BNE: taken = !src_eq;
			npc_pkg::ALU_JAL: taken = 1'b1;
			default:          taken = 1'b0;
		endcase
	end

	// one cycle wide since decode sends a bubble behind it
	assign redirect    = dx_valid && taken;
	assign redirect_pc = dx_pc + dx_imm;

	// ****************************************
	// execute-to-writeback register
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			xw_valid <= 1'b0;
		end else begin
			xw_valid <= dx_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (dx_valid) begin
			xw_pc    <= dx_pc;
			xw_rd    <= dx_rd;
			xw_wen   <= dx_wen;
			xw_wdata <= result;
		end
	end

endmodule

// File: hdl/decode_unit.sv
// decode stage, instruction decode, operand read, busy scoreboard and the decode-to-execute register
module decode_unit (
	input  logic               clk,
	input  logic               rst,
	input  logic               fd_valid,
	input  npc_pkg::xlen_t     fd_pc,
	input  npc_pkg::inst_t     fd_inst,
	input  logic               redirect,
	input  npc_pkg::xlen_t     rs1_data,
	input  npc_pkg::xlen_t     rs2_data,
	input  logic               dx_ready,
	input  logic               rf_wen,
	input  npc_pkg::reg_idx_t  rf_rd,
	output logic               fd_ready,
	output npc_pkg::reg_idx_t  rs1,
	output npc_pkg::reg_idx_t  rs2,
	output logic               dx_valid,
	output npc_pkg::xlen_t     dx_pc,
	output npc_pkg::alu_op_t   dx_op,
	output npc_pkg::xlen_t     dx_src_a,
	output npc_pkg::xlen_t     dx_src_b,
	output npc_pkg::xlen_t     dx_imm,
	output npc_pkg::reg_idx_t  dx_rd,
	output logic               dx_wen
);

	logic [6:0]        opcode;
	logic [2:0]        funct3;
	npc_pkg::reg_idx_t rd;
	npc_pkg::xlen_t    imm_i, imm_u, imm_b, imm_j;
	npc_pkg::alu_op_t  dec_op;
	npc_pkg::xlen_t    dec_imm;
	logic              dec_wen, use_rs1, use_rs2, b_is_imm;
	logic [31:0]       busy;
	logic              stall, issue;

	// instruction fields
	assign opcode = fd_inst[6:0];
	assign funct3 = fd_inst[14:12];
	assign rd     = fd_inst[11:7];
	assign rs1    = fd_inst[19:15];
	assign rs2    = fd_inst[24:20];

	// ****************************************
	// immediates
	// ****************************************
	assign imm_i = {{52{fd_inst[31]}}, fd_inst[31:20]};
	assign imm_u = {{32{fd_inst[31]}}, fd_inst[31:12], 12'b0};
	assign imm_b = {{51{fd_inst[31]}}, fd_inst[31], fd_inst[7], fd_inst[30:25],
		fd_inst[11:8], 1'b0};
	assign imm_j = {{43{fd_inst[31]}}, fd_inst[31], fd_inst[19:12], fd_inst[20],
		fd_inst[30:21], 1'b0};

	// ****************************************
	// opcode decode
	// ****************************************
	always_comb begin
		// unknown encodings fall through as a no-write op that still retires
		dec_op   = npc_pkg::ALU_PASS_B;
		dec_imm  = imm_i;
		dec_wen  = 1'b0;
		use_rs1  = 1'b0;
		use_rs2  = 1'b0;
		b_is_imm = 1'b0;
		case (opcode)
			npc_pkg::OPC_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				dec_wen = 1'b1;
				case (funct3)
					3'b000:  dec_op = fd_inst[30] ? npc_pkg::ALU_SUB : npc_pkg::ALU_ADD;
					3'b100:  dec_op = npc_pkg::ALU_XOR;
					3'b110:  dec_op = npc_pkg::ALU_OR;
					3'b111:  dec_op = npc_pkg::ALU_AND;
					default: dec_wen = 1'b0;
				endcase
			end
			npc_pkg::OPC_OP_IMM: begin
				// only addi, other funct3 values left as no-write
				use_rs1  = 1'b1;
				b_is_imm = 1'b1;
				dec_op   = npc_pkg::ALU_ADD;
				dec_wen  = (funct3 == 3'b000);
			end
			npc_pkg::OPC_LUI: begin
				dec_imm  = imm_u;
				b_is_imm = 1'b1;
				dec_wen  = 1'b1;
			end
			npc_pkg::OPC_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				dec_imm = imm_b;
				if (funct3 == 3'b000) begin
					dec_op = npc_pkg::ALU_BEQ;
				end else if (funct3 == 3'b001) begin
					dec_op = npc_pkg::ALU_BNE;
				end
			end
			npc_pkg::OPC_JAL: begin
				dec_op  = npc_pkg::ALU_JAL;
				dec_imm = imm_j;
				dec_wen = 1'b1;
			end
			default: ;
		endcase
	end

	// ****************************************
	// scoreboard and stall
	// ****************************************
	// only sources actually read count
	assign stall    = fd_valid && ((use_rs1 && busy[rs1]) || (use_rs2 && busy[rs2]));
	assign fd_ready = dx_ready && !stall;
	// no issue while execute redirects
	assign issue    = fd_valid && fd_ready && !redirect;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= '0;
		end else begin
			if (rf_wen) begin
				busy[rf_rd] <= 1'b0;
			end
			// later assignment wins, so release plus re-set leaves it busy
			if (issue && dec_wen && (rd != 5'd0)) begin
				busy[rd] <= 1'b1;
			end
		end
	end

	// ****************************************
	// decode-to-execute register
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			dx_valid <= 1'b0;
		end else if (dx_ready) begin
			// bubble on stall or redirect
			dx_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			dx_pc    <= fd_pc;
			dx_op    <= dec_op;
			dx_src_a <= rs1_data;
			dx_src_b <= b_is_imm ? dec_imm : rs2_data;
			dx_imm   <= dec_imm;
			dx_rd    <= rd;
			dx_wen   <= dec_wen;
		end
	end

endmodule

// File: hdl/fetch_unit.sv
// fetch stage, holds the pc, drives instruction memory and fills the fetch-to-decode register
module fetch_unit (
	input  logic            clk,
	input  logic            rst,
	input  logic            redirect,
	input  npc_pkg::xlen_t  redirect_pc,
	input  npc_pkg::inst_t  imem_data,
	input  logic            fd_ready,
	output npc_pkg::xlen_t  imem_addr,
	output logic            fd_valid,
	output npc_pkg::xlen_t  fd_pc,
	output npc_pkg::inst_t  fd_inst
);

	npc_pkg::xlen_t pc;
	logic           advance;

	// register empty or being taken by decode this cycle
	assign advance = !fd_valid || fd_ready;

	// memory sees the registered pc directly
	assign imem_addr = pc;

	// ****************************************
	// program counter
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= npc_pkg::RESET_PC;
		end else if (redirect) begin
			// redirect wins over a stall
			pc <= redirect_pc;
		end else if (advance) begin
			pc <= pc + 64'd4;
		end
	end

	// ****************************************
	// fetch-to-decode register
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			fd_valid <= 1'b0;
		end else if (redirect) begin
			// younger instr dropped
			fd_valid <= 1'b0;
		end else if (advance) begin
			fd_valid <= 1'b1;
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (!redirect && advance) begin
			fd_pc   <= pc;
			fd_inst <= imem_data;
		end
	end

endmodule

// File: hdl/regfile.sv
// general register file, two combinational read ports and one write port at the clock edge
module regfile (
	input  logic              clk,
	input  npc_pkg::reg_idx_t rs1,
	input  npc_pkg::reg_idx_t rs2,
	input  logic              wen,
	input  npc_pkg::reg_idx_t rd,
	input  npc_pkg::xlen_t    wdata,
	output npc_pkg::xlen_t    rs1_data,
	output npc_pkg::xlen_t    rs2_data
);

	// x1..x31 only, x0 has no storage
	npc_pkg::xlen_t gpr [1:31];

	// ****************************************
	// write port
	// ****************************************
	always_ff @(posedge clk) begin
		// writes to x0 dropped here as well
		if (wen && (rd != 5'd0)) begin
			gpr[rd] <= wdata;
		end
	end

	// ****************************************
	// read ports
	// ****************************************
	// old value returned during a same-cycle write
	// scoreboard keeps readers off busy registers
	assign rs1_data = (rs1 == 5'd0) ? '0 : gpr[rs1];
	assign rs2_data = (rs2 == 5'd0) ? '0 : gpr[rs2];

endmodule

// File: hdl/npc_pkg.sv
// shared widths, reset address, opcodes and execute operation codes for the rv64i pipeline
package npc_pkg;

	// ****************************************
	// datapath widths
	// ****************************************
	localparam int XLEN = 64;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [31:0]     inst_t;
	typedef logic [4:0]      reg_idx_t;

	// first fetch address after reset
	localparam xlen_t RESET_PC = 64'h0000_0000_8000_0000;

	// ****************************************
	// major opcodes, inst[6:0]
	// ****************************************
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	// execute operation selector
	typedef logic [3:0] alu_op_t;

	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_AND    = 4'd2;
	localparam alu_op_t ALU_OR     = 4'd3;
	localparam alu_op_t ALU_XOR    = 4'd4;
	localparam alu_op_t ALU_PASS_B = 4'd5;
	localparam alu_op_t ALU_BEQ    = 4'd6;
	localparam alu_op_t ALU_BNE    = 4'd7;
	localparam alu_op_t ALU_JAL    = 4'd8;

endpackage
